//--- common/rvPkg.sv
package rvPkg;

    localparam int xlen      = 32;
    localparam int regAddrW  = 5;
    localparam int wordAddrW = 30;

    typedef enum logic [6:0] {
        opLoad   = 7'b0000011,
        opOpImm  = 7'b0010011,
        opStore  = 7'b0100011,
        opOp     = 7'b0110011,
        opBranch = 7'b1100011,
        opJalr   = 7'b1100111,
        opJal    = 7'b1101111
    } opcodeT;

    typedef enum logic [3:0] {
        aluAnd = 4'd0,
        aluOr  = 4'd1,
        aluAdd = 4'd2,
        aluSub = 4'd3,
        aluSlt = 4'd4,
        aluSll = 4'd5,
        aluSrl = 4'd6,
        aluSra = 4'd7,
        aluXor = 4'd8
    } aluOpT;

    typedef struct packed {
        aluOpT aluOp;
        logic  aluSrcImm;   // operand b from imm
    } exCtrlT;

    typedef struct packed {
        logic memRead;
        logic memWrite;
    } memCtrlT;

    typedef struct packed {
        logic regWrite;
        logic memToReg;
        logic isLink;       // writes pc+4
    } wbCtrlT;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcodeT     opcode;
    } rTypeT;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcodeT      opcode;
    } iTypeT;

    typedef struct packed {
        logic [6:0] immHi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;
        opcodeT     opcode;
    } sTypeT;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        opcodeT     opcode;
    } bTypeT;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        opcodeT     opcode;
    } jTypeT;

    // same word, seen as register fields or as immediate fields
    typedef union packed {
        rTypeT r;
        iTypeT i;
        sTypeT s;
        bTypeT b;
        jTypeT j;
    } instrWordT;

endpackage

//--- common/decExIf.sv
`timescale 1ns/10ps

interface decExIf;
    import rvPkg::*;

    exCtrlT              exCtrl;
    memCtrlT             memCtrl;
    wbCtrlT              wbCtrl;
    logic [xlen-1:0]     rs1Val;
    logic [xlen-1:0]     rs2Val;
    logic [xlen-1:0]     imm;
    logic [xlen-1:0]     pcPlus4;
    logic [regAddrW-1:0] rs1;
    logic [regAddrW-1:0] rs2;
    logic [regAddrW-1:0] rd;

    modport decOut (
        output exCtrl, memCtrl, wbCtrl, rs1Val, rs2Val, imm, pcPlus4, rs1, rs2, rd
    );

    modport exIn (
        input exCtrl, memCtrl, wbCtrl, rs1Val, rs2Val, imm, pcPlus4, rs1, rs2, rd
    );

endinterface

//--- common/exResIf.sv
`timescale 1ns/10ps

interface exResIf;
    import rvPkg::*;

    memCtrlT             memCtrl;
    wbCtrlT              wbCtrl;
    logic [xlen-1:0]     aluOut;
    logic [xlen-1:0]     storeData;
    logic [xlen-1:0]     pcPlus4;
    logic [regAddrW-1:0] rd;

    modport exOut (output memCtrl, wbCtrl, aluOut, storeData, pcPlus4, rd);

    modport resIn (input memCtrl, wbCtrl, aluOut, storeData, pcPlus4, rd);

endinterface

//--- common/bypassIf.sv
`timescale 1ns/10ps

interface bypassIf;
    import rvPkg::*;

    // EX/MEM side
    logic                memRegWrite;
    logic                memIsLoad;
    logic [regAddrW-1:0] memRd;
    logic [xlen-1:0]     memValue;
    // MEM/WB side
    logic                wbRegWrite;
    logic [regAddrW-1:0] wbRd;
    logic [xlen-1:0]     wbValue;

    modport src (output memRegWrite, memIsLoad, memRd, memValue, wbRegWrite, wbRd, wbValue);

    modport sink (input memRegWrite, memIsLoad, memRd, memValue, wbRegWrite, wbRd, wbValue);

endinterface

//--- decode/instrDecoder.sv
`timescale 1ns/10ps

module instrDecoder (
    input  rvPkg::instrWordT        instr,
    output rvPkg::exCtrlT           exCtrl,
    output rvPkg::memCtrlT          memCtrl,
    output rvPkg::wbCtrlT           wbCtrl,
    output logic                    isBranch,
    output logic                    isJump,
    output logic                    isJalr,
    output logic [rvPkg::xlen-1:0]  imm
);
    import rvPkg::*;

    logic [xlen-1:0] immI, immS, immB, immJ;
    aluOpT           functOp;
    logic            alt;

    assign immI = {{20{instr.i.imm[11]}}, instr.i.imm};
    assign immS = {{20{instr.s.immHi[6]}}, instr.s.immHi, instr.s.immLo};
    assign immB = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                   instr.b.imm10_5, instr.b.imm4_1, 1'b0};
    assign immJ = {{11{instr.j.imm20}}, instr.j.imm20, instr.j.imm19_12,
                   instr.j.imm11, instr.j.imm10_1, 1'b0};

    // funct7[5] picks sub and sra
    assign alt = instr.r.funct7[5];

    always_comb begin
        case (instr.r.funct3)
            3'b000:  functOp = (alt && instr.r.opcode == opOp) ? aluSub : aluAdd;
            3'b001:  functOp = aluSll;
            3'b010:  functOp = aluSlt;
            3'b100:  functOp = aluXor;
            3'b101:  functOp = alt ? aluSra : aluSrl;
            3'b110:  functOp = aluOr;
            3'b111:  functOp = aluAnd;
            default: functOp = aluAdd;
        endcase
    end

    always_comb begin
        exCtrl   = '0;
        memCtrl  = '0;
        wbCtrl   = '0;
        isBranch = 1'b0;
        isJump   = 1'b0;
        isJalr   = 1'b0;
        imm      = immI;
        exCtrl.aluOp = aluAdd;
        case (instr.r.opcode)
            opOp: begin
                exCtrl.aluOp    = functOp;
                wbCtrl.regWrite = 1'b1;
            end
            opOpImm: begin
                exCtrl          = '{aluOp: functOp, aluSrcImm: 1'b1};
                wbCtrl.regWrite = 1'b1;
            end
            opLoad: begin
                exCtrl.aluSrcImm = 1'b1;
                memCtrl.memRead  = 1'b1;
                wbCtrl           = '{regWrite: 1'b1, memToReg: 1'b1, isLink: 1'b0};
            end
            opStore: begin
                exCtrl.aluSrcImm = 1'b1;
                memCtrl.memWrite = 1'b1;
                imm              = immS;
            end
            opBranch: begin
                isBranch = 1'b1;
                imm      = immB;
            end
            opJal: begin
                isJump = 1'b1;
                wbCtrl = '{regWrite: 1'b1, memToReg: 1'b0, isLink: 1'b1};
                imm    = immJ;
            end
            opJalr: begin
                isJump = 1'b1;
                isJalr = 1'b1;
                wbCtrl = '{regWrite: 1'b1, memToReg: 1'b0, isLink: 1'b1};
            end
            default: exCtrl = '0;   // unknown opcode, bubble
        endcase
        if (instr.r.rd == '0)
            wbCtrl.regWrite = 1'b0;
    end

endmodule

//--- decode/regFile.sv
`timescale 1ns/10ps

module regFile (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [rvPkg::regAddrW-1:0]    rs1,
    input  logic [rvPkg::regAddrW-1:0]    rs2,
    input  logic [rvPkg::regAddrW-1:0]    wrAddr,
    input  logic                          wrEn,
    input  logic [rvPkg::xlen-1:0]        wrData,
    output logic [rvPkg::xlen-1:0]        rd1,
    output logic [rvPkg::xlen-1:0]        rd2
);
    import rvPkg::*;

    logic [xlen-1:0] regs [32];

    assign rd1 = regs[rs1];
    assign rd2 = regs[rs2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (wrEn) begin
            regs[wrAddr] <= wrData;
        end
    end

    // x0 stays zero only because the decoder drops rd==0 writes
    noWriteX0: assert property (
        @(posedge clk) disable iff (!rst_n) wrEn |-> wrAddr != '0
    );

endmodule

//--- decode/decodeStage.sv
`timescale 1ns/10ps

module decodeStage #(
    parameter logic [rvPkg::xlen-1:0] resetPc = '0
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       dStall,
    output logic [rvPkg::wordAddrW-1:0] iAddr,
    input  logic [rvPkg::xlen-1:0]      iData,
    decExIf.decOut                     dec,
    bypassIf.sink                      byp
);
    import rvPkg::*;

    logic [xlen-1:0] pc;
    logic [xlen-1:0] ifPc;
    instrWordT       ifInstr;

    exCtrlT          exCtrl;
    memCtrlT         memCtrl;
    wbCtrlT          wbCtrl;
    logic            isBranch, isJump, isJalr;
    logic [xlen-1:0] imm;

    logic [regAddrW-1:0] rs1, rs2;
    logic [xlen-1:0]     rf1, rf2, rs1Fwd, rs2Fwd;
    logic [xlen-1:0]     jumpBase, target;
    logic                ldUse, brHaz, hold, taken, flush;

    assign iAddr = pc[xlen-1:2];
    assign rs1   = ifInstr.r.rs1;
    assign rs2   = ifInstr.r.rs2;

    instrDecoder u_instrDecoder (
        .instr    (ifInstr),
        .exCtrl   (exCtrl),
        .memCtrl  (memCtrl),
        .wbCtrl   (wbCtrl),
        .isBranch (isBranch),
        .isJump   (isJump),
        .isJalr   (isJalr),
        .imm      (imm)
    );

    regFile u_regFile (
        .clk    (clk),
        .rst_n  (rst_n),
        .rs1    (rs1),
        .rs2    (rs2),
        .wrAddr (byp.wbRd),
        .wrEn   (byp.wbRegWrite),
        .wrData (byp.wbValue),
        .rd1    (rf1),
        .rd2    (rf2)
    );

    // mem stage wins over wb, wb over the array
    assign rs1Fwd = (byp.memRegWrite && byp.memRd == rs1) ? byp.memValue :
                    (byp.wbRegWrite && byp.wbRd == rs1)   ? byp.wbValue  : rf1;
    assign rs2Fwd = (byp.memRegWrite && byp.memRd == rs2) ? byp.memValue :
                    (byp.wbRegWrite && byp.wbRd == rs2)   ? byp.wbValue  : rf2;

    assign ldUse = dec.memCtrl.memRead && dec.wbCtrl.regWrite &&
                   (dec.rd == rs1 || dec.rd == rs2);
    // comparator and jalr base need final values in decode
    assign brHaz = (isBranch || isJalr) &&
                   ((dec.wbCtrl.regWrite && (dec.rd == rs1 || dec.rd == rs2)) ||
                    (byp.memIsLoad && byp.memRegWrite &&
                     (byp.memRd == rs1 || byp.memRd == rs2)));
    assign hold  = ldUse || brHaz;

    // funct3[0] set means bne
    assign taken    = isJump ||
                      (isBranch && ((rs1Fwd == rs2Fwd) != ifInstr.b.funct3[0]));
    assign flush    = taken && !hold;
    assign jumpBase = isJalr ? rs1Fwd : ifPc;
    assign target   = (jumpBase + imm) & ~{{(xlen-1){1'b0}}, isJalr};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc      <= resetPc;
            ifPc    <= '0;
            ifInstr <= '0;
        end else if (!dStall && !hold) begin
            pc   <= flush ? target : pc + 4;
            ifPc <= pc;
            if (flush)
                ifInstr <= '0;  // kill the slot behind the jump
            else
                ifInstr <= iData;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dec.exCtrl  <= '0;
            dec.memCtrl <= '0;
            dec.wbCtrl  <= '0;
            dec.rs1Val  <= '0;
            dec.rs2Val  <= '0;
            dec.imm     <= '0;
            dec.pcPlus4 <= '0;
            dec.rs1     <= '0;
            dec.rs2     <= '0;
            dec.rd      <= '0;
        end else if (!dStall) begin
            dec.exCtrl  <= hold ? '0 : exCtrl;
            dec.memCtrl <= hold ? '0 : memCtrl;
            dec.wbCtrl  <= hold ? '0 : wbCtrl;
            dec.rs1Val  <= rs1Fwd;
            dec.rs2Val  <= rs2Fwd;
            dec.imm     <= imm;
            dec.pcPlus4 <= ifPc + 4;
            dec.rs1     <= rs1;
            dec.rs2     <= rs2;
            dec.rd      <= ifInstr.r.rd;
        end
    end

    // killed slot never redirects fetch
    killedSlotIdle: assert property (
        @(posedge clk) disable iff (!rst_n) flush && !dStall |=> !taken
    );

endmodule

//--- source/executeStage.sv
`timescale 1ns/10ps

module executeStage (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   dStall,
    decExIf.exIn   dec,
    exResIf.exOut  res,
    bypassIf.sink  byp
);
    import rvPkg::*;

    logic [xlen-1:0] opA, rs2Fwd, opB, aluOut;
    logic [4:0]      shamt;

    assign opA = (byp.memRegWrite && byp.memRd == dec.rs1) ? byp.memValue :
                 (byp.wbRegWrite && byp.wbRd == dec.rs1)   ? byp.wbValue  : dec.rs1Val;
    assign rs2Fwd = (byp.memRegWrite && byp.memRd == dec.rs2) ? byp.memValue :
                    (byp.wbRegWrite && byp.wbRd == dec.rs2)   ? byp.wbValue  : dec.rs2Val;
    assign opB   = dec.exCtrl.aluSrcImm ? dec.imm : rs2Fwd;
    assign shamt = opB[4:0];

    always_comb begin
        case (dec.exCtrl.aluOp)
            aluAnd:  aluOut = opA & opB;
            aluOr:   aluOut = opA | opB;
            aluAdd:  aluOut = opA + opB;
            aluSub:  aluOut = opA - opB;
            aluSlt:  aluOut = {{(xlen-1){1'b0}}, $signed(opA) < $signed(opB)};
            aluSll:  aluOut = opA << shamt;
            aluSrl:  aluOut = opA >> shamt;
            aluSra:  aluOut = $signed(opA) >>> shamt;
            aluXor:  aluOut = opA ^ opB;
            default: aluOut = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res.memCtrl   <= '0;
            res.wbCtrl    <= '0;
            res.aluOut    <= '0;
            res.storeData <= '0;
            res.pcPlus4   <= '0;
            res.rd        <= '0;
        end else if (!dStall) begin
            res.memCtrl   <= dec.memCtrl;
            res.wbCtrl    <= dec.wbCtrl;
            res.aluOut    <= aluOut;
            res.storeData <= rs2Fwd;    // sw data, not the imm
            res.pcPlus4   <= dec.pcPlus4;
            res.rd        <= dec.rd;
        end
    end

    aluOpDefined: assert property (
        @(posedge clk) disable iff (!rst_n)
        dec.exCtrl.aluOp inside {aluAnd, aluOr, aluAdd, aluSub, aluSlt,
                                 aluSll, aluSrl, aluSra, aluXor}
    );

endmodule

//--- source/resultStage.sv
`timescale 1ns/10ps

module resultStage (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        dStall,
    exResIf.resIn                       res,
    bypassIf.src                        byp,
    output logic                        dRen,
    output logic                        dWen,
    output logic [rvPkg::wordAddrW-1:0] dAddr,
    output logic [rvPkg::xlen-1:0]      dWdata,
    input  logic [rvPkg::xlen-1:0]      dRdata
);
    import rvPkg::*;

    logic            wbMemToReg;
    logic [xlen-1:0] wbLoad, wbAlu;

    assign dRen   = res.memCtrl.memRead;
    assign dWen   = res.memCtrl.memWrite;
    assign dAddr  = res.aluOut[xlen-1:2];
    assign dWdata = res.storeData;

    assign byp.memRegWrite = res.wbCtrl.regWrite;
    assign byp.memIsLoad   = res.memCtrl.memRead;
    assign byp.memRd       = res.rd;
    assign byp.memValue    = res.wbCtrl.isLink ? res.pcPlus4 : res.aluOut;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            byp.wbRegWrite <= 1'b0;
            byp.wbRd       <= '0;
            wbMemToReg     <= 1'b0;
            wbLoad         <= '0;
            wbAlu          <= '0;
        end else if (!dStall) begin   // dRdata only good with dStall low
            byp.wbRegWrite <= res.wbCtrl.regWrite;
            byp.wbRd       <= res.rd;
            wbMemToReg     <= res.wbCtrl.memToReg;
            wbLoad         <= dRdata;
            wbAlu          <= byp.memValue;
        end
    end

    assign byp.wbValue = wbMemToReg ? wbLoad : wbAlu;

    noReadWrite: assert property (
        @(posedge clk) disable iff (!rst_n) !(dRen && dWen)
    );

endmodule

//--- source/rvPipeline.sv
`timescale 1ns/10ps

module rvPipeline #(
    parameter logic [rvPkg::xlen-1:0] resetPc = '0
) (
    input  logic                       clk,
    input  logic                       rst_n,
    output logic [rvPkg::wordAddrW-1:0] iAddr,
    input  logic [rvPkg::xlen-1:0]      iData,
    output logic                       dRen,
    output logic                       dWen,
    output logic [rvPkg::wordAddrW-1:0] dAddr,
    output logic [rvPkg::xlen-1:0]      dWdata,
    input  logic [rvPkg::xlen-1:0]      dRdata,
    input  logic                       dStall
);

    decExIf  decEx ();
    exResIf  exRes ();
    bypassIf byp ();

    decodeStage #(.resetPc(resetPc)) u_decodeStage (
        .clk    (clk),
        .rst_n  (rst_n),
        .dStall (dStall),
        .iAddr  (iAddr),
        .iData  (iData),
        .dec    (decEx.decOut),
        .byp    (byp.sink)
    );

    executeStage u_executeStage (
        .clk    (clk),
        .rst_n  (rst_n),
        .dStall (dStall),
        .dec    (decEx.exIn),
        .res    (exRes.exOut),
        .byp    (byp.sink)
    );

    resultStage u_resultStage (
        .clk    (clk),
        .rst_n  (rst_n),
        .dStall (dStall),
        .res    (exRes.resIn),
        .byp    (byp.src),
        .dRen   (dRen),
        .dWen   (dWen),
        .dAddr  (dAddr),
        .dWdata (dWdata),
        .dRdata (dRdata)
    );

endmodule

//--- tests/rvMemModel.sv
`timescale 1ns/10ps

module rvMemModel (
    input  logic        clk,
    input  logic        stallOn,
    input  logic [29:0] iAddr,
    output logic [31:0] iData,
    input  logic        dRen,
    input  logic        dWen,
    input  logic [29:0] dAddr,
    input  logic [31:0] dWdata,
    output logic [31:0] dRdata,
    output logic        dStall
);

    logic [31:0] rom [256];     // filled by the testbench
    logic [31:0] ram [256];

    // same-cycle answers on both ports
    assign iData  = rom[iAddr[7:0]];
    assign dRdata = dRen ? ram[dAddr[7:0]] : '0;

    initial begin
        for (int a = 0; a < 256; a++)
            ram[a] = {~a[7:0], a[7:0], ~a[7:0], a[7:0]};
    end

    always @(posedge clk) begin
        if (dWen && !dStall)
            ram[dAddr[7:0]] <= dWdata;
    end

    // roughly one cycle in four stalled once enabled
    initial begin
        void'($urandom(98432));
        dStall = 1'b0;
        forever begin
            @(posedge clk);
            dStall <= stallOn && ($urandom_range(3) == 0);
        end
    end

endmodule

//--- tests/tbRvPipeline.sv
`timescale 1ns/10ps

module tbRvPipeline;

    localparam int          clkPeriod = 100;
    localparam int          maxStores = 32;
    localparam logic [31:0] resetPc   = 32'h0000_0040;
    localparam logic [31:0] storeBase = 32'h0000_0100;
    localparam logic [31:0] skipByte  = storeBase + 32'h200;   // stores that must never run
    localparam logic [6:0]  opImm     = 7'b0010011;
    localparam logic [6:0]  opLd      = 7'b0000011;
    localparam logic [6:0]  opJr      = 7'b1100111;

    logic        clk;
    logic        rst_n;
    logic        stallOn;
    logic [29:0] iAddr;
    logic [31:0] iData;
    logic        dRen;
    logic        dWen;
    logic [29:0] dAddr;
    logic [31:0] dWdata;
    logic [31:0] dRdata;
    logic        dStall;

    logic [29:0] expAddr [maxStores];
    logic [31:0] expData [maxStores];
    string       expName [maxStores];
    int          nStores  = 0;
    int          pIdx     = 0;
    int          storeIdx = 0;
    int          slot     = 0;      // table entry of the next store
    int          errors   = 0;
    logic [29:0] curAddr;
    logic [31:0] curData;

    rvPipeline #(.resetPc(resetPc)) u_rvPipeline (
        .clk    (clk),
        .rst_n  (rst_n),
        .iAddr  (iAddr),
        .iData  (iData),
        .dRen   (dRen),
        .dWen   (dWen),
        .dAddr  (dAddr),
        .dWdata (dWdata),
        .dRdata (dRdata),
        .dStall (dStall)
    );

    rvMemModel u_rvMemModel (
        .clk     (clk),
        .stallOn (stallOn),
        .iAddr   (iAddr),
        .iData   (iData),
        .dRen    (dRen),
        .dWen    (dWen),
        .dAddr   (dAddr),
        .dWdata  (dWdata),
        .dRdata  (dRdata),
        .dStall  (dStall)
    );

    initial clk = 1'b0;
    always #(clkPeriod / 2) clk = ~clk;

    function automatic logic [31:0] encR(logic [6:0] f7, logic [2:0] f3, int rd, int rs1, int rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] encI(logic [6:0] op, logic [2:0] f3, int rd, int rs1, int imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
    endfunction

    function automatic logic [31:0] encS(int rs2, int rs1, int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] encB(logic [2:0] f3, int rs1, int rs2, int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] encJ(int rd, int imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    task automatic emit(logic [31:0] word);
        u_rvMemModel.rom[resetPc[9:2] + pIdx] = word;
        pIdx++;
    endtask

    // sw rs2 to the next free slot, plus its table entry
    task automatic storeCheck(string name, int rs2, logic [31:0] value);
        int off;
        off = 4 * nStores;
        emit(encS(rs2, 31, off));
        expAddr[nStores] = (storeBase + off) >> 2;
        expData[nStores] = value;
        expName[nStores] = name;
        nStores++;
    endtask

    task automatic emitSkipped();
        emit(encS(0, 31, 32'h200));
    endtask

    task automatic buildProgram();
        logic [31:0] a, b, c, link;
        int          off7, off14;
        a = -37;
        b = 1234;
        c = 7;
        for (int i = 0; i < 256; i++)
            u_rvMemModel.rom[i] = encI(opImm, 3'b000, 0, 0, i);    // addi x0 filler
        emit(encI(opImm, 3'b000, 31, 0, storeBase));
        emit(encI(opImm, 3'b000, 1, 0, -37));
        emit(encI(opImm, 3'b000, 2, 0, 1234));
        emit(encR(7'h00, 3'b000, 3, 1, 2));
        storeCheck("add", 3, a + b);
        emit(encR(7'h20, 3'b000, 4, 1, 2));
        storeCheck("sub", 4, a - b);
        emit(encR(7'h00, 3'b111, 5, 1, 2));
        emit(encR(7'h00, 3'b110, 6, 1, 2));
        emit(encR(7'h00, 3'b100, 7, 1, 2));
        storeCheck("and", 5, a & b);
        storeCheck("or", 6, a | b);
        storeCheck("xor", 7, a ^ b);
        emit(encR(7'h00, 3'b010, 8, 1, 2));
        emit(encR(7'h00, 3'b010, 9, 2, 1));
        storeCheck("slt", 8, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
        storeCheck("slt_rev", 9, ($signed(b) < $signed(a)) ? 32'd1 : 32'd0);
        emit(encI(opImm, 3'b000, 10, 0, 20));     // shift amount above 15
        emit(encR(7'h00, 3'b001, 11, 1, 10));
        emit(encR(7'h00, 3'b101, 12, 1, 10));
        emit(encR(7'h20, 3'b101, 13, 1, 10));
        storeCheck("sll", 11, a << 20);
        storeCheck("srl", 12, a >> 20);
        storeCheck("sra", 13, $signed(a) >>> 20);
        emit(encI(opImm, 3'b001, 14, 2, 17));
        emit(encI(opImm, 3'b101, 15, 1, 28));
        emit(encI(opImm, 3'b101, 16, 1, 12'h400 + 18));
        storeCheck("slli", 14, b << 17);
        storeCheck("srli", 15, a >> 28);
        storeCheck("srai", 16, $signed(a) >>> 18);
        emit(encI(opImm, 3'b111, 17, 1, 12'h0F0));
        emit(encI(opImm, 3'b110, 18, 2, -256));
        emit(encI(opImm, 3'b100, 19, 1, 12'h7FF));
        emit(encI(opImm, 3'b010, 20, 1, -36));
        storeCheck("andi", 17, a & 32'h0000_00F0);
        storeCheck("ori", 18, b | 32'hFFFF_FF00);
        storeCheck("xori", 19, a ^ 32'h0000_07FF);
        storeCheck("slti", 20, ($signed(a) < -36) ? 32'd1 : 32'd0);
        emit(encI(opImm, 3'b000, 0, 1, 55));
        storeCheck("x0_write", 0, 32'd0);
        // dependency chain at distances one to three
        emit(encI(opImm, 3'b000, 21, 0, c));
        emit(encR(7'h00, 3'b000, 22, 21, 21));
        emit(encI(opImm, 3'b000, 23, 21, 3));
        emit(encR(7'h20, 3'b000, 24, 22, 21));
        off7 = 4 * nStores;
        storeCheck("fwd_sub", 24, (c + c) - c);
        storeCheck("fwd_addi", 23, c + 3);
        off14 = 4 * nStores;
        storeCheck("fwd_add", 22, c + c);
        emit(encI(opLd, 3'b010, 25, 31, off7));
        emit(encI(opImm, 3'b000, 26, 25, 100));
        storeCheck("load_use", 26, c + 100);
        emit(encI(opLd, 3'b010, 27, 31, off14));
        emit(encB(3'b000, 27, 22, 8));
        emitSkipped();
        storeCheck("load_beq", 27, c + c);
        emit(encB(3'b001, 21, 21, 8));
        storeCheck("bne_not_taken", 21, c);
        emit(encB(3'b001, 21, 22, 8));
        emitSkipped();
        emit(encB(3'b000, 21, 22, 8));
        storeCheck("beq_not_taken", 22, c + c);
        emit(encB(3'b000, 21, 21, 8));
        emitSkipped();
        link = resetPc + 4 * pIdx + 4;
        emit(encJ(29, 8));
        emitSkipped();
        storeCheck("jal_link", 29, link);
        emit(encI(opImm, 3'b000, 30, 29, 20));      // jalr target, one slot past the next sw
        link = resetPc + 4 * pIdx + 4;
        emit(encI(opJr, 3'b000, 28, 30, 0));
        emitSkipped();
        storeCheck("jalr_link", 28, link);
        emit(encJ(0, -4 * pIdx));                   // back to resetPc
    endtask

    always @(posedge clk) begin
        if (rst_n && dWen && !dStall) begin
            storeIdx <= storeIdx + 1;
            slot     <= (slot + 1 == nStores) ? 0 : slot + 1;
        end
    end

    assign curAddr = expAddr[slot];
    assign curData = expData[slot];

    storeAddrOk: assert property (
        @(posedge clk) disable iff (!rst_n) (dWen && !dStall) |-> dAddr == curAddr
    ) else begin
        errors++;
        $display("FAIL %s addr expected %h actual %h",
                 expName[$sampled(slot)], $sampled(curAddr), $sampled(dAddr));
    end

    storeDataOk: assert property (
        @(posedge clk) disable iff (!rst_n) (dWen && !dStall) |-> dWdata == curData
    ) else begin
        errors++;
        $display("FAIL %s data expected %h actual %h",
                 expName[$sampled(slot)], $sampled(curData), $sampled(dWdata));
    end

    noSkippedStore: assert property (
        @(posedge clk) disable iff (!rst_n) dWen |-> dAddr != skipByte[31:2]
    ) else begin
        errors++;
        $display("store behind a taken branch or jump reached the data port");
    end

    stallHold: assert property (
        @(posedge clk) disable iff (!rst_n) dStall |=> $stable({dRen, dWen, dAddr, dWdata})
    ) else begin
        errors++;
        $display("data port changed while dStall was high");
    end

    resetFetch: assert property (
        @(posedge clk) $rose(rst_n) |-> iAddr == resetPc[31:2]
    ) else begin
        errors++;
        $display("FAIL reset iAddr expected %h actual %h", resetPc[31:2], $sampled(iAddr));
    end

    resetPortIdle: assert property (
        @(posedge clk) $rose(rst_n) |-> !dRen && !dWen
    ) else begin
        errors++;
        $display("data port was not idle in the first cycle after reset");
    end

    initial begin
        int limitCycles;
        rst_n   = 1'b0;
        stallOn = 1'b0;
        buildProgram();
        limitCycles = 2 * pIdx * 3 * 2 + 10;
        fork
            begin
                #(limitCycles * clkPeriod);
                $display("timeout after %0d cycles, %0d of %0d stores seen, errors: %0d",
                         limitCycles, storeIdx, 2 * nStores, errors);
                $display("SIMULATION FAILED");
                $finish;
            end
        join_none
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        while (storeIdx < nStores)
            @(posedge clk);
        stallOn <= 1'b1;    // second pass runs under random stalls
        while (storeIdx < 2 * nStores)
            @(posedge clk);
        repeat (2) @(posedge clk);
        $display("stores checked: %0d, errors: %0d", storeIdx, errors);
        if (errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

//--- files.f
common/rvPkg.sv
common/decExIf.sv
common/exResIf.sv
common/bypassIf.sv
decode/instrDecoder.sv
decode/regFile.sv
decode/decodeStage.sv
source/executeStage.sv
source/resultStage.sv
source/rvPipeline.sv
tests/rvMemModel.sv
tests/tbRvPipeline.sv
